//--- design/isa_pkg.sv
package isa_pkg;

	localparam int REG_IDX_W = 3;
	localparam int NUM_REGS = 2 ** REG_IDX_W;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Major opcode in bits 15:11 of every word
	typedef enum logic [4:0] {
		OP_HALT = 5'b00000,
		OP_NOP  = 5'b00001,
		OP_ADDI = 5'b01000,
		OP_BEQZ = 5'b01100,
		OP_BNEZ = 5'b01101,
		OP_ST   = 5'b10000,
		OP_LD   = 5'b10001,
		OP_LBI  = 5'b11000,
		OP_ALU  = 5'b11011
	} opcode_t;

	// ADD, SUB, AND, XOR; func picks the operation
	typedef struct packed {
		opcode_t    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [1:0] func;
	} r_view_t;

	// ADDI, LD, ST; imm is two's complement
	typedef struct packed {
		opcode_t    opcode;
		reg_idx_t   rs;
		reg_idx_t   rd;
		logic [4:0] imm;
	} i_view_t;

	// LBI and the branches
	typedef struct packed {
		opcode_t    opcode;
		reg_idx_t   rs;
		logic [7:0] imm;
	} l_view_t;

	typedef union packed {
		r_view_t r;
		i_view_t i;
		l_view_t l;
	} instr_t;

	localparam logic [15:0] NOP_WORD = {OP_NOP, 11'd0};

endpackage

//--- design/pipe_pkg.sv
package pipe_pkg;

	// Same encoding as the func field of a register-format word
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_AND = 2'b10,
		ALU_XOR = 2'b11
	} alu_op_t;

	// Writeback source
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_sel_t;

endpackage

//--- design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import isa_pkg::*; #(
	parameter int IMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        imem_we,
	input  logic [15:0] imem_addr,
	input  instr_t      imem_data,
	input  logic        stall,
	input  logic        halt_seen,
	input  logic        branch_taken,
	input  logic [15:0] branch_target,
	output instr_t      instruction,
	output logic [15:0] pc
);

	localparam int IA_W = $clog2(IMEM_WORDS);

	instr_t      imem [IMEM_WORDS];
	logic [15:0] pc_f;
	instr_t      fetch_word;

	// External load port
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr[IA_W-1:0]] <= imem_data;
		end
	end

	assign fetch_word = imem[pc_f[IA_W-1:0]];

	// Redirect wins over stall, stall wins over halt
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc_f <= '0;
			instruction <= NOP_WORD;
		end else if (branch_taken) begin
			pc_f <= branch_target;
			instruction <= NOP_WORD;
		end else if (!stall) begin
			if (halt_seen) begin
				instruction <= NOP_WORD;
			end else begin
				pc_f <= pc_f + 16'd1;
				instruction <= fetch_word;
			end
		end
	end

	// PC of the word now in fetch/decode
	always_ff @(posedge clk) begin
		if (branch_taken || !stall) begin
			pc <= pc_f;
		end
	end

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  instr_t      instruction,
	input  logic [15:0] pc,
	input  logic        branch_taken,
	input  logic        wb_en,
	input  reg_idx_t    wb_reg,
	input  logic [15:0] wb_data,
	output logic        stall,
	output logic        halt_seen,
	output logic [15:0] rs_val,
	output logic [15:0] rt_val,
	output logic [15:0] imm,
	output reg_idx_t    rs_idx,
	output reg_idx_t    rt_idx,
	output reg_idx_t    rd_idx,
	output alu_op_t     alu_op,
	output wb_sel_t     wb_sel,
	output logic        alu_b_imm,
	output logic        alu_a_zero,
	output logic        mem_read,
	output logic        mem_write,
	output logic        reg_write,
	output logic        is_beqz,
	output logic        is_bnez,
	output logic        is_halt,
	output logic        is_illegal,
	output logic [15:0] pc_q
);

	logic [15:0] rf [NUM_REGS];
	reg_idx_t    rs_rd;
	reg_idx_t    rt_rd;
	logic [15:0] rs_data;
	logic [15:0] rt_data;
	logic [15:0] imm5_ext;
	logic [15:0] imm8_ext;
	logic [15:0] dec_imm;
	reg_idx_t    dec_rd;
	alu_op_t     dec_alu_op;
	wb_sel_t     dec_wb_sel;
	logic        dec_b_imm;
	logic        dec_a_zero;
	logic        dec_mem_read;
	logic        dec_mem_write;
	logic        dec_reg_write;
	logic        dec_beqz;
	logic        dec_bnez;
	logic        dec_halt;
	logic        dec_illegal;
	logic        bubble;
	logic        halt_hold;

	assign imm5_ext = {{11{instruction.i.imm[4]}}, instruction.i.imm};
	assign imm8_ext = {{8{instruction.l.imm[7]}}, instruction.l.imm};

	always_comb begin
		dec_alu_op = ALU_ADD;
		dec_wb_sel = WB_ALU;
		dec_imm = imm5_ext;
		dec_rd = instruction.i.rd;
		dec_b_imm = 1'b1;
		dec_a_zero = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_reg_write = 1'b0;
		dec_beqz = 1'b0;
		dec_bnez = 1'b0;
		dec_halt = 1'b0;
		dec_illegal = 1'b0;
		case (instruction.r.opcode)
			OP_ALU: begin
				dec_alu_op = alu_op_t'(instruction.r.func);
				dec_rd = instruction.r.rd;
				dec_b_imm = 1'b0;
				dec_reg_write = 1'b1;
			end
			OP_ADDI: dec_reg_write = 1'b1;
			OP_LD: begin
				dec_mem_read = 1'b1;
				dec_reg_write = 1'b1;
				dec_wb_sel = WB_MEM;
			end
			OP_ST: dec_mem_write = 1'b1;
			OP_LBI: begin
				// Destination sits in the rs field
				dec_imm = imm8_ext;
				dec_rd = instruction.l.rs;
				dec_a_zero = 1'b1;
				dec_reg_write = 1'b1;
			end
			OP_BEQZ: begin
				dec_imm = imm8_ext;
				dec_beqz = 1'b1;
			end
			OP_BNEZ: begin
				dec_imm = imm8_ext;
				dec_bnez = 1'b1;
			end
			OP_HALT: dec_halt = 1'b1;
			OP_NOP: begin
				// Nothing to do
			end
			default: begin
				dec_halt = 1'b1;
				dec_illegal = 1'b1;
			end
		endcase
	end

	// Register file, written at the end of writeback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_en) begin
			rf[wb_reg] <= wb_data;
		end
	end

	// ST data register shares bits 7:5 with rt
	assign rs_rd = instruction.r.rs;
	assign rt_rd = instruction.r.rt;
	assign rs_data = (wb_en && wb_reg == rs_rd) ? wb_data : rf[rs_rd];
	assign rt_data = (wb_en && wb_reg == rt_rd) ? wb_data : rf[rt_rd];

	// Load in execute feeding this instruction
	assign stall = mem_read && (rd_idx == rs_rd || rd_idx == rt_rd);
	assign bubble = stall || branch_taken;

	assign halt_seen = halt_hold || (dec_halt && !branch_taken);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			halt_hold <= 1'b0;
		end else if (dec_halt && !bubble) begin
			halt_hold <= 1'b1;
		end
	end

	// Decode/execute control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			reg_write <= 1'b0;
			is_beqz <= 1'b0;
			is_bnez <= 1'b0;
			is_halt <= 1'b0;
			is_illegal <= 1'b0;
		end else begin
			mem_read <= dec_mem_read && !bubble;
			mem_write <= dec_mem_write && !bubble;
			reg_write <= dec_reg_write && !bubble;
			is_beqz <= dec_beqz && !bubble;
			is_bnez <= dec_bnez && !bubble;
			is_halt <= dec_halt && !bubble;
			is_illegal <= dec_illegal && !bubble;
		end
	end

	// Decode/execute payload
	always_ff @(posedge clk) begin
		rs_val <= rs_data;
		rt_val <= rt_data;
		imm <= dec_imm;
		rs_idx <= rs_rd;
		rt_idx <= rt_rd;
		rd_idx <= dec_rd;
		alu_op <= dec_alu_op;
		wb_sel <= dec_wb_sel;
		alu_b_imm <= dec_b_imm;
		alu_a_zero <= dec_a_zero;
		pc_q <= pc;
	end

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] rs_val,
	input  logic [15:0] rt_val,
	input  logic [15:0] imm,
	input  reg_idx_t    rs_idx,
	input  reg_idx_t    rt_idx,
	input  reg_idx_t    rd_idx,
	input  alu_op_t     alu_op,
	input  wb_sel_t     wb_sel,
	input  logic        alu_b_imm,
	input  logic        alu_a_zero,
	input  logic        mem_read,
	input  logic        mem_write,
	input  logic        reg_write,
	input  logic        is_beqz,
	input  logic        is_bnez,
	input  logic        is_halt,
	input  logic        is_illegal,
	input  logic [15:0] pc_q,
	input  logic        mem_wb_reg_write,
	input  reg_idx_t    mem_wb_rd,
	input  logic [15:0] mem_wb_data,
	output logic        branch_taken,
	output logic [15:0] branch_target,
	output logic [15:0] alu_q,
	output logic [15:0] store_q,
	output reg_idx_t    rd_q,
	output wb_sel_t     wb_sel_q,
	output logic        mem_read_q,
	output logic        mem_write_q,
	output logic        reg_write_q,
	output logic        halt_q,
	output logic        illegal_q
);

	logic [15:0] a_fwd;
	logic [15:0] b_fwd;
	logic [15:0] op_a;
	logic [15:0] op_b;
	logic [15:0] alu_res;

	// Newest producer first; loads in execute/memory are covered by the stall
	function automatic logic [15:0] bypass(input reg_idx_t idx, input logic [15:0] reg_val);
		if (reg_write_q && wb_sel_q == WB_ALU && rd_q == idx) begin
			return alu_q;
		end else if (mem_wb_reg_write && mem_wb_rd == idx) begin
			return mem_wb_data;
		end
		return reg_val;
	endfunction

	always_comb begin
		a_fwd = bypass(rs_idx, rs_val);
		b_fwd = bypass(rt_idx, rt_val);
	end

	assign op_a = alu_a_zero ? 16'd0 : a_fwd;
	assign op_b = alu_b_imm ? imm : b_fwd;

	// SUB is rs - rt
	always_comb begin
		case (alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_AND: alu_res = op_a & op_b;
			default: alu_res = op_a ^ op_b;
		endcase
	end

	assign branch_taken = (is_beqz && a_fwd == 16'd0) || (is_bnez && a_fwd != 16'd0);
	assign branch_target = pc_q + 16'd1 + imm;

	// Execute/memory control
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_read_q <= 1'b0;
			mem_write_q <= 1'b0;
			reg_write_q <= 1'b0;
			halt_q <= 1'b0;
			illegal_q <= 1'b0;
		end else begin
			mem_read_q <= mem_read;
			mem_write_q <= mem_write;
			reg_write_q <= reg_write;
			halt_q <= is_halt;
			illegal_q <= is_illegal;
		end
	end

	// Address or result, plus store data
	always_ff @(posedge clk) begin
		alu_q <= alu_res;
		store_q <= b_fwd;
		rd_q <= rd_idx;
		wb_sel_q <= wb_sel;
	end

endmodule

//--- design/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import isa_pkg::*, pipe_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] alu_q,
	input  logic [15:0] store_q,
	input  reg_idx_t    rd_q,
	input  wb_sel_t     wb_sel_q,
	input  logic        mem_read_q,
	input  logic        mem_write_q,
	input  logic        reg_write_q,
	input  logic        halt_q,
	input  logic        illegal_q,
	output logic        wb_en,
	output reg_idx_t    wb_reg,
	output logic [15:0] wb_data,
	output logic [15:0] fwd_data,
	output logic        halted,
	output logic        err
);

	localparam int DA_W = $clog2(DMEM_WORDS);

	logic [15:0] dmem [DMEM_WORDS] = '{default: 16'd0};
	logic [15:0] alu_w;
	logic [15:0] load_w;
	wb_sel_t     wb_sel_w;
	logic [15:0] wb_result;

	always_ff @(posedge clk) begin
		if (mem_write_q) begin
			dmem[alu_q[DA_W-1:0]] <= store_q;
		end
	end

	// Memory/writeback payload
	always_ff @(posedge clk) begin
		wb_reg <= rd_q;
		alu_w <= alu_q;
		wb_sel_w <= wb_sel_q;
		if (mem_read_q) begin
			load_w <= dmem[alu_q[DA_W-1:0]];
		end
	end

	// halted and err are sticky until reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_en <= 1'b0;
			halted <= 1'b0;
			err <= 1'b0;
		end else begin
			wb_en <= reg_write_q;
			halted <= halted || halt_q;
			err <= err || illegal_q;
		end
	end

	assign wb_result = (wb_sel_w == WB_MEM) ? load_w : alu_w;

	// One result feeds both the register file and the bypass into execute
	assign wb_data = wb_result;
	assign fwd_data = wb_result;

endmodule

//--- design/proc.sv
`timescale 1ns/1ps

module proc import isa_pkg::*, pipe_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        imem_we,
	input  logic [15:0] imem_addr,
	input  instr_t      imem_data,
	output logic        wb_en,
	output reg_idx_t    wb_reg,
	output logic [15:0] wb_data,
	output logic        halted,
	output logic        err
);

	// Fetch/decode
	instr_t      instruction;
	logic [15:0] pc;
	logic        stall;
	logic        halt_seen;

	// Decode/execute
	logic [15:0] rs_val;
	logic [15:0] rt_val;
	logic [15:0] imm;
	reg_idx_t    rs_idx;
	reg_idx_t    rt_idx;
	reg_idx_t    rd_idx;
	alu_op_t     alu_op;
	wb_sel_t     wb_sel;
	logic        alu_b_imm;
	logic        alu_a_zero;
	logic        mem_read;
	logic        mem_write;
	logic        reg_write;
	logic        is_beqz;
	logic        is_bnez;
	logic        is_halt;
	logic        is_illegal;
	logic [15:0] pc_q;

	// Branch redirect
	logic        branch_taken;
	logic [15:0] branch_target;

	// Execute/memory
	logic [15:0] alu_q;
	logic [15:0] store_q;
	reg_idx_t    rd_q;
	wb_sel_t     wb_sel_q;
	logic        mem_read_q;
	logic        mem_write_q;
	logic        reg_write_q;
	logic        halt_q;
	logic        illegal_q;
	logic [15:0] fwd_data;

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) fetch_inst (.*);

	decode_stage decode_inst (.*);

	execute_stage execute_inst (
		.*,
		.mem_wb_reg_write (wb_en),
		.mem_wb_rd        (wb_reg),
		.mem_wb_data      (fwd_data)
	);

	mem_wb_stage #(.DMEM_WORDS(DMEM_WORDS)) mem_wb_inst (.*);

endmodule

//--- verif/proc_properties.sv
`timescale 1ns/1ps

module proc_properties (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic branch_taken,
	input logic halted,
	input logic wb_en
);

	int failure_count = 0;

	// Stall bubble reaches writeback three cycles on
	stall_no_write: assert property (
		@(posedge clk) disable iff (!rst_n) stall |-> ##3 !wb_en
	) else begin
		$error("Stall bubble wrote a register at writeback");
		failure_count++;
	end

	// Both slots squashed by a taken branch
	flush_no_write: assert property (
		@(posedge clk) disable iff (!rst_n) branch_taken |-> ##3 !wb_en ##1 !wb_en
	) else begin
		$error("Instruction flushed by a taken branch wrote a register");
		failure_count++;
	end

	// Sticky until reset, and nothing retires after it
	halted_holds: assert property (
		@(posedge clk) disable iff (!rst_n) halted |=> halted && !wb_en
	) else begin
		$error("halted dropped or a register write followed it");
		failure_count++;
	end

	// Pipeline leaves reset holding only NOPs
	empty_after_reset: assert property (
		@(posedge clk) $rose(rst_n) |-> !wb_en ##1 !wb_en ##1 !wb_en ##1 !wb_en
	) else begin
		$error("wb_en high before the first instruction could reach writeback");
		failure_count++;
	end

endmodule

bind proc proc_properties props_inst (
	.clk          (clk),
	.rst_n        (rst_n),
	.stall        (stall),
	.branch_taken (branch_taken),
	.halted       (halted),
	.wb_en        (wb_en)
);

//--- verif/proc_tb.sv
`timescale 1ns/1ps

module proc_tb import isa_pkg::*; ();

	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;
	localparam int DA_W = $clog2(DMEM_WORDS);
	localparam int PROG_LEN = 64;
	localparam int NUM_PROGS = 8;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * (PROG_LEN * 3 + 40);
	localparam int QUIET_CYCLES = 8;

	logic        clk;
	logic        rst_n;
	logic        imem_we;
	logic [15:0] imem_addr;
	instr_t      imem_data;
	logic        wb_en;
	reg_idx_t    wb_reg;
	logic [15:0] wb_data;
	logic        halted;
	logic        err;

	logic [31:0] lfsr;
	int          error_count;
	int          run_cycles = 0;
	instr_t      prog [PROG_LEN];
	logic [15:0] model_regs [NUM_REGS];
	logic [15:0] model_mem [DMEM_WORDS];
	logic        model_err;
	reg_idx_t    exp_reg [$];
	logic [15:0] exp_data [$];

	proc #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) proc_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Counts only cycles where the core runs
	always @(posedge clk) begin
		if (rst_n) begin
			run_cycles <= run_cycles + 1;
		end
	end

	// Galois LFSR, one step per bit
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return bits;
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		if (got !== expected) begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h at %0t", name, got, expected,
				$time);
			error_count++;
		end
	endtask

	task automatic make_program(input bit end_illegal);
		instr_t     w;
		logic [2:0] kind;
		int         last_st;
		last_st = -1;
		for (int idx = 0; idx < PROG_LEN - 1; idx++) begin
			w = instr_t'(NOP_WORD);
			kind = 3'(take_bits(3));
			case (kind)
				3'd0: begin
					w.r.opcode = OP_ALU;
					w.r.rs = 3'(take_bits(3));
					w.r.rt = 3'(take_bits(3));
					w.r.rd = 3'(take_bits(3));
					w.r.func = 2'(take_bits(2));
				end
				3'd1, 3'd2, 3'd3: begin
					case (kind)
						3'd1: w.i.opcode = OP_ADDI;
						3'd2: w.i.opcode = OP_LD;
						default: w.i.opcode = OP_ST;
					endcase
					w.i.rs = 3'(take_bits(3));
					w.i.rd = 3'(take_bits(3));
					w.i.imm = 5'(take_bits(5));
					// Half the loads reuse the address of the latest store
					if (kind == 3'd2 && last_st >= 0 && take_bits(1) == 1) begin
						w.i.rs = prog[last_st].i.rs;
						w.i.imm = prog[last_st].i.imm;
					end
					if (kind == 3'd3) begin
						last_st = idx;
					end
				end
				3'd4: begin
					w.l.opcode = OP_LBI;
					w.l.rs = 3'(take_bits(3));
					w.l.imm = 8'(take_bits(8));
				end
				3'd5, 3'd6: begin
					w.l.opcode = (kind == 3'd5) ? OP_BEQZ : OP_BNEZ;
					w.l.rs = 3'(take_bits(3));
					// Forward only, never past the last word
					w.l.imm = 8'(take_bits(3) % (PROG_LEN - 1 - idx));
				end
				default: begin
				end
			endcase
			prog[idx] = w;
		end
		if (end_illegal) begin
			prog[PROG_LEN-1] = instr_t'({5'b11111, 11'(take_bits(11))});
		end else begin
			prog[PROG_LEN-1] = instr_t'({OP_HALT, 11'd0});
		end
	endtask

	task automatic write_reg(input reg_idx_t idx, input logic [15:0] value);
		model_regs[idx] = value;
		exp_reg.push_back(idx);
		exp_data.push_back(value);
	endtask

	// ISA-level execution of prog, one instruction at a time
	task automatic run_model();
		instr_t      w;
		int          pc;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] ea;
		bit          done;
		pc = 0;
		done = 1'b0;
		model_err = 1'b0;
		exp_reg.delete();
		exp_data.delete();
		for (int i = 0; i < NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		while (!done && pc < PROG_LEN) begin
			w = prog[pc];
			pc++;
			a = model_regs[w.r.rs];
			b = model_regs[w.r.rt];
			ea = a + {{11{w.i.imm[4]}}, w.i.imm};
			case (w.r.opcode)
				OP_ALU: begin
					case (w.r.func)
						2'd0: write_reg(w.r.rd, a + b);
						2'd1: write_reg(w.r.rd, a - b);
						2'd2: write_reg(w.r.rd, a & b);
						default: write_reg(w.r.rd, a ^ b);
					endcase
				end
				OP_ADDI: write_reg(w.i.rd, ea);
				OP_LD: write_reg(w.i.rd, model_mem[ea[DA_W-1:0]]);
				OP_ST: model_mem[ea[DA_W-1:0]] = model_regs[w.i.rd];
				OP_LBI: write_reg(w.l.rs, {{8{w.l.imm[7]}}, w.l.imm});
				OP_BEQZ: pc = (a == 16'd0) ? pc + int'(w.l.imm) : pc;
				OP_BNEZ: pc = (a != 16'd0) ? pc + int'(w.l.imm) : pc;
				OP_NOP: begin
				end
				OP_HALT: done = 1'b1;
				default: begin
					done = 1'b1;
					model_err = 1'b1;
				end
			endcase
		end
	endtask

	task automatic load_program();
		for (int idx = 0; idx < PROG_LEN; idx++) begin
			@(posedge clk);
			#1;
			imem_we = 1'b1;
			imem_addr = 16'(idx);
			imem_data = prog[idx];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
	endtask

	task automatic observe_write();
		if (wb_en) begin
			if (exp_reg.size() == 0) begin
				$display("Unexpected write of 0x%h to r%0d after the last expected write",
					wb_data, wb_reg);
				error_count++;
			end else begin
				check_value("wb_reg", {13'd0, wb_reg}, {13'd0, exp_reg.pop_front()});
				check_value("wb_data", wb_data, exp_data.pop_front());
			end
		end
	endtask

	task automatic run_program(input int num, input bit end_illegal);
		int writes;
		make_program(end_illegal);
		run_model();
		writes = exp_reg.size();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		load_program();
		// Reset stays low 16 cycles past the load
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (!halted) begin
			@(posedge clk);
			#1;
			observe_write();
		end
		check_value("pending_writes", 16'(exp_reg.size()), 16'd0);
		repeat (QUIET_CYCLES) begin
			@(posedge clk);
			#1;
			observe_write();
		end
		check_value("halted", {15'd0, halted}, 16'd1);
		check_value("err", {15'd0, err}, {15'd0, model_err});
		$display("Program %0d finished with %0d register writes", num, writes);
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = proc_inst.props_inst.failure_count;
		$display("Closing count: %0d check errors, %0d assertion failures", error_count,
			assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	initial begin
		wait (run_cycles >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles: the core never halted", run_cycles);
		error_count++;
		finish_run();
	end

	initial begin
		rst_n = 1'b0;
		imem_we = 1'b0;
		imem_addr = '0;
		imem_data = instr_t'(NOP_WORD);
		lfsr = 32'ha86a_668d;
		error_count = 0;
		// Data memory keeps its contents across programs
		for (int i = 0; i < DMEM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		for (int num = 0; num < NUM_PROGS; num++) begin
			run_program(num, num == NUM_PROGS - 1);
		end
		finish_run();
	end

endmodule

//--- files.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/proc.sv
verif/proc_properties.sv
verif/proc_tb.sv

//--- Makefile
TOP := proc_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -qx "tests failed" sim.log; then exit 1; fi
	@grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
